// File: verilog.f
common/unpack_pkg.sv
design/unpack_fsm.sv
design/header_decoder.sv
design/bram_reader.sv
router/rx_router.sv
router/randombit_packer.sv
design/b_unpacket_top.sv
test/tb_b_unpacket.sv

// File: Makefile
SIM  := obj_dir/Vtb_b_unpacket
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_b_unpacket -f verilog.f -o Vtb_b_unpacket

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_b_unpacket.sv
`default_nettype none

module tb_b_unpacket;
    import unpack_pkg::*;

    localparam logic [3:0] WAIT_NEXT_STATE = 4'd5;
    // Payload words over every packet the tests send, and the packet count
    localparam int DEPTH_SUM      = 512 + 37 + 768 + 1 + 2 * 10 + 5 + 33 * 2;
    localparam int PACKETS        = 1 + 2 + 1 + 2 + 1 + 33;
    localparam int TIMEOUT_CYCLES = 2 * DEPTH_SUM + 40 * PACKETS;

    logic       clk;
    logic       rst_n;
    logic       msg_accessed;
    logic       busy_net2pp_rx;
    logic       decoy_full;
    logic       er_full;
    logic       clear_ev;
    word_t      rx_rdata = '0;
    logic       busy_pp2net_rx;
    rx_addr_t   rx_addr;
    fifo_wr_t   er_wr;
    fifo_wr_t   decoy_wr;
    fifo_wr_t   sklen_wr;
    rand_wr_t   ev_wr;
    logic       ev_full;
    logic [3:0] unpack_state;

    word_t      mem [0:2047];
    word_t      er_q[$];
    word_t      decoy_q[$];
    word_t      sklen_q[$];
    rand_wr_t   ev_q[$];
    integer     seed = 32'h697e;
    int         cycle_cnt = 0;
    pkt_type_e  cur_type;
    int         cur_depth;
    rand_addr_t ev_addr_model = '0;

    b_unpacket_top #(
        .EV_BANK_PACKETS (32)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .msg_accessed   (msg_accessed),
        .busy_net2pp_rx (busy_net2pp_rx),
        .decoy_full     (decoy_full),
        .er_full        (er_full),
        .clear_ev       (clear_ev),
        .rx_rdata       (rx_rdata),
        .busy_pp2net_rx (busy_pp2net_rx),
        .rx_addr        (rx_addr),
        .er_wr          (er_wr),
        .decoy_wr       (decoy_wr),
        .sklen_wr       (sklen_wr),
        .ev_wr          (ev_wr),
        .ev_full        (ev_full),
        .unpack_state   (unpack_state)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // RX block RAM with one cycle of read latency
    always @(posedge clk) begin
        rx_rdata <= mem[rx_addr];
    end

    // Sink monitors sample on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (er_wr.en) er_q.push_back(er_wr.din);
            if (decoy_wr.en) decoy_q.push_back(decoy_wr.din);
            if (sklen_wr.en) sklen_q.push_back(sklen_wr.din);
            if (ev_wr.we) ev_q.push_back(ev_wr);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("TEST FAILED");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Word check failed");
        end
    endtask

    task automatic compare_rand(input string name, input rand_wr_t exp, input rand_wr_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "EV write check failed");
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Count check failed");
        end
    endtask

    function automatic word_t ram_word(input int a);
        return mem[a[10:0]];
    endfunction

    // Payload depth as given by the length code
    function automatic int payload_depth(input pkt_len_e len, input logic [8:0] short_depth);
        case (len)
            LEN_257: return int'(short_depth);
            LEN_514: return 512;
            LEN_771: return 768;
            default: return 1024;
        endcase
    endfunction

    task automatic load_packet(input pkt_type_e t, input pkt_len_e len,
                               input logic [8:0] short_depth);
        rx_header_t hdr;
        word_t      rnd;
        rnd = $random(seed);
        hdr.pkt_type    = t;
        hdr.pkt_len     = len;
        hdr.short_depth = short_depth;
        hdr.reserved    = rnd[14:0];
        mem[0] = hdr;
        cur_type  = t;
        cur_depth = payload_depth(len, short_depth);
        for (int a = 1; a <= cur_depth; a++) begin
            mem[a[10:0]] = $random(seed);
        end
        er_q.delete();
        decoy_q.delete();
        sklen_q.delete();
        ev_q.delete();
    endtask

    task automatic check_sinks(input string name);
        int       n_er;
        int       n_decoy;
        int       n_sklen;
        int       n_ev;
        rand_wr_t exp_wr;
        n_er    = 0;
        n_decoy = 0;
        n_sklen = 0;
        n_ev    = 0;
        case (cur_type)
            TYPE_CORRECT_PARITY, TYPE_TARGET_HASHTAG: n_er = cur_depth + 1;
            TYPE_Z_BASIS_DECOY: n_decoy = cur_depth;
            TYPE_SECRETKEY_LENGTH: n_sklen = cur_depth;
            TYPE_EV_RANDOMBIT: n_ev = cur_depth / 2;
            default: n_er = 0;
        endcase
        compare_count({name, " er count"}, n_er, er_q.size());
        compare_count({name, " decoy count"}, n_decoy, decoy_q.size());
        compare_count({name, " sklen count"}, n_sklen, sklen_q.size());
        compare_count({name, " ev count"}, n_ev, ev_q.size());
        // ER stream starts with the header at address 0
        for (int i = 0; i < er_q.size(); i++) begin
            compare_word($sformatf("%s er word %0d", name, i), ram_word(i), er_q[i]);
        end
        for (int i = 0; i < decoy_q.size(); i++) begin
            compare_word($sformatf("%s decoy word %0d", name, i), ram_word(i + 1), decoy_q[i]);
        end
        for (int i = 0; i < sklen_q.size(); i++) begin
            compare_word($sformatf("%s sklen word %0d", name, i), ram_word(i + 1), sklen_q[i]);
        end
        for (int i = 0; i < ev_q.size(); i++) begin
            exp_wr.we   = 1'b1;
            exp_wr.addr = ev_addr_model;
            exp_wr.din  = {ram_word(2 * i + 1), ram_word(2 * i + 2)};
            compare_rand($sformatf("%s ev write %0d", name, i), exp_wr, ev_q[i]);
            ev_addr_model = ev_addr_model + 14'd1;
        end
    endtask

    // Raise the message, let the packet run, then withdraw it
    task automatic finish_packet(input string name);
        @(posedge clk);
        msg_accessed <= 1'b1;
        @(negedge clk);
        while (!busy_pp2net_rx) @(negedge clk);
        while (unpack_state != WAIT_NEXT_STATE) @(negedge clk);
        @(posedge clk);
        msg_accessed <= 1'b0;
        @(negedge clk);
        while (busy_pp2net_rx) @(negedge clk);
        check_sinks(name);
    endtask

    task automatic send_packet(input string name, input pkt_type_e t, input pkt_len_e len,
                               input logic [8:0] short_depth);
        load_packet(t, len, short_depth);
        finish_packet(name);
    endtask

    task automatic pulse_clear_ev();
        @(posedge clk);
        clear_ev <= 1'b1;
        @(posedge clk);
        clear_ev <= 1'b0;
        ev_addr_model = '0;
        @(negedge clk);
    endtask

    task automatic test_decoy_514();
        send_packet("decoy_514", TYPE_Z_BASIS_DECOY, LEN_514, 9'd0);
    endtask

    task automatic test_er_packets();
        send_packet("parity_37", TYPE_CORRECT_PARITY, LEN_257, 9'd37);
        send_packet("hashtag_771", TYPE_TARGET_HASHTAG, LEN_771, 9'd0);
    endtask

    task automatic test_sklen_single();
        send_packet("sklen_1", TYPE_SECRETKEY_LENGTH, LEN_257, 9'd1);
    endtask

    task automatic test_ev_pairs();
        send_packet("ev_pairs_a", TYPE_EV_RANDOMBIT, LEN_257, 9'd10);
        send_packet("ev_pairs_b", TYPE_EV_RANDOMBIT, LEN_257, 9'd10);
    endtask

    // A full ER FIFO holds the message off until released
    task automatic test_er_full_hold();
        load_packet(TYPE_CORRECT_PARITY, LEN_257, 9'd5);
        @(posedge clk);
        er_full      <= 1'b1;
        msg_accessed <= 1'b1;
        repeat (20) begin
            @(negedge clk);
            compare_count("er_full_hold busy", 0, int'(busy_pp2net_rx));
            compare_count("er_full_hold writes", 0,
                          er_q.size() + decoy_q.size() + sklen_q.size() + ev_q.size());
        end
        @(posedge clk);
        er_full <= 1'b0;
        finish_packet("er_full_hold");
    endtask

    task automatic test_ev_bank_full();
        pulse_clear_ev();
        compare_count("ev_bank start full", 0, int'(ev_full));
        for (int k = 0; k < 32; k++) begin
            send_packet($sformatf("ev_bank packet %0d", k), TYPE_EV_RANDOMBIT, LEN_257, 9'd2);
            compare_count($sformatf("ev_bank full after %0d", k + 1), (k == 31) ? 1 : 0,
                          int'(ev_full));
        end
        pulse_clear_ev();
        compare_count("ev_bank full after clear", 0, int'(ev_full));
        // Model address is back at 0, so the first write is checked there
        send_packet("ev_bank after clear", TYPE_EV_RANDOMBIT, LEN_257, 9'd2);
        compare_count("ev_bank full after new packet", 0, int'(ev_full));
    endtask

    initial begin
        rst_n          <= 1'b0;
        msg_accessed   <= 1'b0;
        busy_net2pp_rx <= 1'b0;
        decoy_full     <= 1'b0;
        er_full        <= 1'b0;
        clear_ev       <= 1'b0;
        for (int a = 0; a < 2048; a++) begin
            mem[a[10:0]] = $random(seed);
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_decoy_514();
        test_er_packets();
        test_sklen_single();
        test_ev_pairs();
        test_er_full_hold();
        test_ev_bank_full();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/b_unpacket_top.sv
`default_nettype none

module b_unpacket_top #(
    parameter int unsigned EV_BANK_PACKETS = 32
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 msg_accessed,
    input  wire logic                 busy_net2pp_rx,
    input  wire logic                 decoy_full,
    input  wire logic                 er_full,
    input  wire logic                 clear_ev,
    input  wire unpack_pkg::word_t    rx_rdata,
    output wire logic                 busy_pp2net_rx,
    output wire unpack_pkg::rx_addr_t rx_addr,
    output wire unpack_pkg::fifo_wr_t er_wr,
    output wire unpack_pkg::fifo_wr_t decoy_wr,
    output wire unpack_pkg::fifo_wr_t sklen_wr,
    output wire unpack_pkg::rand_wr_t ev_wr,
    output wire logic                 ev_full,
    output wire logic [3:0]           unpack_state
);
    import unpack_pkg::*;

    unpack_ctrl_t ctrl;
    logic         stream_done;
    word_t        rdata_q;
    fifo_wr_t     payload;
    pkt_type_e    pkt_type;
    depth_t       depth;
    fifo_wr_t     ev_word;
    logic         ev_packet_done;

    unpack_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .msg_accessed   (msg_accessed),
        .busy_net2pp_rx (busy_net2pp_rx),
        .decoy_full     (decoy_full),
        .er_full        (er_full),
        .stream_done    (stream_done),
        .ctrl           (ctrl),
        .busy_pp2net_rx (busy_pp2net_rx),
        .state          (unpack_state)
    );

    header_decoder u_header (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .rdata_q  (rdata_q),
        .pkt_type (pkt_type),
        .depth    (depth)
    );

    bram_reader u_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .depth       (depth),
        .pkt_type    (pkt_type),
        .rx_rdata    (rx_rdata),
        .rx_addr     (rx_addr),
        .rdata_q     (rdata_q),
        .payload     (payload),
        .stream_done (stream_done)
    );

    rx_router u_router (
        .pkt_type       (pkt_type),
        .payload        (payload),
        .ctrl           (ctrl),
        .er_wr          (er_wr),
        .decoy_wr       (decoy_wr),
        .sklen_wr       (sklen_wr),
        .ev_word        (ev_word),
        .ev_packet_done (ev_packet_done)
    );

    randombit_packer #(
        .EV_BANK_PACKETS (EV_BANK_PACKETS)
    ) u_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .ev_word        (ev_word),
        .ev_packet_done (ev_packet_done),
        .clear_ev       (clear_ev),
        .ev_wr          (ev_wr),
        .ev_full        (ev_full)
    );

endmodule

`default_nettype wire

// File: router/randombit_packer.sv
`default_nettype none

module randombit_packer #(
    parameter int unsigned EV_BANK_PACKETS = 32
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire unpack_pkg::fifo_wr_t ev_word,
    input  wire logic                 ev_packet_done,
    input  wire logic                 clear_ev,
    output unpack_pkg::rand_wr_t      ev_wr,
    output logic                      ev_full
);
    import unpack_pkg::*;

    localparam int CNT_W = $clog2(EV_BANK_PACKETS + 1);

    word_t            prev_word;
    logic             phase;
    logic             write;
    rand_addr_t       addr_q;
    logic [CNT_W-1:0] bank_cnt;

    // Second word of each pair completes a 64-bit write
    assign write = ev_word.en && phase;

    always_ff @(posedge clk) begin
        if (ev_word.en) begin
            prev_word <= ev_word.din;
        end
    end

    // An odd trailing word is dropped when the packet ends
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else if (ev_packet_done) begin
            phase <= 1'b0;
        end else if (ev_word.en) begin
            phase <= ~phase;
        end
    end

    // Address wraps at the end of the 16K-entry RAM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (clear_ev) begin
            addr_q <= '0;
        end else if (write) begin
            addr_q <= addr_q + 14'd1;
        end
    end

    // Completed EV packets in the current bank, held at full
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_cnt <= '0;
        end else if (clear_ev) begin
            bank_cnt <= '0;
        end else if (ev_packet_done && !ev_full) begin
            bank_cnt <= bank_cnt + 1'b1;
        end
    end

    assign ev_full = (bank_cnt == CNT_W'(EV_BANK_PACKETS));

    always_comb begin
        ev_wr.we   = write;
        ev_wr.addr = addr_q;
        ev_wr.din  = write ? {prev_word, ev_word.din} : '0;
    end

endmodule

`default_nettype wire

// File: router/rx_router.sv
`default_nettype none

module rx_router (
    input  wire unpack_pkg::pkt_type_e    pkt_type,
    input  wire unpack_pkg::fifo_wr_t     payload,
    input  wire unpack_pkg::unpack_ctrl_t ctrl,
    output unpack_pkg::fifo_wr_t          er_wr,
    output unpack_pkg::fifo_wr_t          decoy_wr,
    output unpack_pkg::fifo_wr_t          sklen_wr,
    output unpack_pkg::fifo_wr_t          ev_word,
    output logic                          ev_packet_done
);
    import unpack_pkg::*;

    // Exactly one sink sees the stream, the rest stay at zero
    always_comb begin
        er_wr    = '0;
        decoy_wr = '0;
        sklen_wr = '0;
        ev_word  = '0;
        case (pkt_type)
            TYPE_CORRECT_PARITY, TYPE_TARGET_HASHTAG: begin
                er_wr = payload;
            end
            TYPE_Z_BASIS_DECOY: begin
                decoy_wr = payload;
            end
            TYPE_SECRETKEY_LENGTH: begin
                sklen_wr = payload;
            end
            TYPE_EV_RANDOMBIT: begin
                ev_word = payload;
            end
            // PA random bits and unknown codes have no sink on this node
            default: begin
            end
        endcase
    end

    // Header is still held during the done cycle
    assign ev_packet_done = ctrl.packet_end && (pkt_type == TYPE_EV_RANDOMBIT);

endmodule

`default_nettype wire

// File: design/bram_reader.sv
`default_nettype none

module bram_reader (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire unpack_pkg::unpack_ctrl_t ctrl,
    input  wire unpack_pkg::depth_t       depth,
    input  wire unpack_pkg::pkt_type_e    pkt_type,
    input  wire unpack_pkg::word_t        rx_rdata,
    output unpack_pkg::rx_addr_t          rx_addr,
    output unpack_pkg::word_t             rdata_q,
    output unpack_pkg::fifo_wr_t          payload,
    output logic                          stream_done
);
    import unpack_pkg::*;

    // Counter value to matching read word: address register, RAM, read register
    localparam depth_t READ_LAG = 11'd3;

    depth_t cnt;
    depth_t first_cnt;
    logic   er_type;
    logic   window;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (ctrl.packet_end) begin
            cnt <= '0;
        end else if (ctrl.stream_en) begin
            cnt <= cnt + 11'd1;
        end
    end

    // Address walks 0..depth during the stream and parks at 0 otherwise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_addr <= '0;
        end else if (ctrl.stream_en && (cnt <= depth)) begin
            rx_addr <= rx_addr_t'(cnt);
        end else begin
            rx_addr <= '0;
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= rx_rdata;
    end

    assign er_type = (pkt_type == TYPE_CORRECT_PARITY) || (pkt_type == TYPE_TARGET_HASHTAG);

    // ER packets start one word early to pass the header through
    assign first_cnt = READ_LAG + 11'd1 - (er_type ? HEADER_PASS_LEAD : 11'd0);

    assign window = ctrl.stream_en && (cnt >= first_cnt) && (cnt <= depth + READ_LAG);

    always_comb begin
        payload.en  = window;
        payload.din = window ? rdata_q : '0;
    end

    assign stream_done = ctrl.stream_en && (cnt == depth + STREAM_END_PAD);

endmodule

`default_nettype wire

// File: design/header_decoder.sv
`default_nettype none

module header_decoder (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire unpack_pkg::unpack_ctrl_t ctrl,
    input  wire unpack_pkg::word_t        rdata_q,
    output unpack_pkg::pkt_type_e         pkt_type,
    output unpack_pkg::depth_t            depth
);
    import unpack_pkg::*;

    rx_header_t hdr_q;

    // Header stays valid from the gap cycle through the done cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_q <= '0;
        end else if (ctrl.read_header) begin
            hdr_q <= rx_header_t'(rdata_q);
        end else if (ctrl.packet_end) begin
            hdr_q <= '0;
        end
    end

    assign pkt_type = hdr_q.pkt_type;

    // Only the shortest length carries its own word count
    always_comb begin
        case (hdr_q.pkt_len)
            LEN_257: begin
                depth = depth_t'(hdr_q.short_depth);
            end
            LEN_514: begin
                depth = 11'd512;
            end
            LEN_771: begin
                depth = 11'd768;
            end
            LEN_1028: begin
                depth = 11'd1024;
            end
            default: begin
                depth = 11'd1024;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/unpack_fsm.sv
`default_nettype none

module unpack_fsm (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     msg_accessed,
    input  wire logic                     busy_net2pp_rx,
    input  wire logic                     decoy_full,
    input  wire logic                     er_full,
    input  wire logic                     stream_done,
    output unpack_pkg::unpack_ctrl_t      ctrl,
    output logic                          busy_pp2net_rx,
    output logic [3:0]                    state
);
    import unpack_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE        = 4'd0,
        ST_READ_HEADER = 4'd1,
        ST_SET_GAP     = 4'd2,
        ST_STREAM      = 4'd3,
        ST_DONE        = 4'd4,
        ST_WAIT_NEXT   = 4'd5
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   start;

    // A packet may only start with room in both FIFOs
    assign start = msg_accessed && !busy_net2pp_rx && !decoy_full && !er_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_READ_HEADER;
                end
            end
            ST_READ_HEADER: begin
                state_d = ST_SET_GAP;
            end
            // One spare cycle so the decoded depth settles before streaming
            ST_SET_GAP: begin
                state_d = ST_STREAM;
            end
            ST_STREAM: begin
                if (stream_done) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_WAIT_NEXT;
            end
            // Hold until the network side withdraws the current message
            ST_WAIT_NEXT: begin
                if (!msg_accessed) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Moore outputs
    always_comb begin
        ctrl             = '0;
        ctrl.read_header = (state_q == ST_READ_HEADER);
        ctrl.stream_en   = (state_q == ST_STREAM);
        ctrl.packet_end  = (state_q == ST_DONE);
    end

    assign busy_pp2net_rx = (state_q != ST_IDLE);
    assign state          = state_q;

endmodule

`default_nettype wire

// File: common/unpack_pkg.sv
`default_nettype none

package unpack_pkg;

    typedef logic [31:0] word_t;
    typedef logic [10:0] rx_addr_t;
    typedef logic [10:0] depth_t;
    typedef logic [13:0] rand_addr_t;

    // Packet type codes carried in the header
    typedef enum logic [3:0] {
        TYPE_Z_BASIS_DECOY    = 4'd1,
        TYPE_CORRECT_PARITY   = 4'd2,
        TYPE_TARGET_HASHTAG   = 4'd3,
        TYPE_SECRETKEY_LENGTH = 4'd4,
        TYPE_EV_RANDOMBIT     = 4'd5,
        TYPE_PA_RANDOMBIT     = 4'd6
    } pkt_type_e;

    // Packet length codes
    typedef enum logic [3:0] {
        LEN_257  = 4'd0,
        LEN_514  = 4'd1,
        LEN_771  = 4'd2,
        LEN_1028 = 4'd3
    } pkt_len_e;

    // Header word sent to the ER FIFO ahead of the payload
    localparam depth_t HEADER_PASS_LEAD = 11'd1;
    // Read counter cycles past the depth before the packet ends
    localparam depth_t STREAM_END_PAD = 11'd9;

    // Header word at RX RAM address 0
    typedef struct packed {
        pkt_type_e   pkt_type;
        pkt_len_e    pkt_len;
        logic [8:0]  short_depth;
        logic [14:0] reserved;
    } rx_header_t;

    // Strobes from the packet FSM
    typedef struct packed {
        logic read_header;
        logic stream_en;
        logic packet_end;
    } unpack_ctrl_t;

    // FIFO write port
    typedef struct packed {
        logic  en;
        word_t din;
    } fifo_wr_t;

    // EV random-bit RAM write port
    typedef struct packed {
        logic        we;
        rand_addr_t  addr;
        logic [63:0] din;
    } rand_wr_t;

endpackage

`default_nettype wire
